// ==== Makefile ====
TOP := tb_ldg

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f verilog/*.sv verification/*.sv
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module ldg_assembly

clean:
	rm -rf obj_dir

// ==== sources.f ====
verilog/ldg_pkg.sv
verilog/ldg_slr_fifo.sv
verilog/ldg_main.sv
verilog/ldg_subs.sv
verilog/ldg_assembly.sv
verification/ldg_checker.sv
verification/tb_ldg.sv

// ==== verification/ldg_checker.sv ====
// Samples on the falling edge; assumes one command in flight and a constant gid_offset
`default_nettype none

module ldg_checker
  import ldg_pkg::*;
(
  input  logic                                     clk,
  input  logic                                     s_rst_n,
  input  int                                       test_idx,
  input  int                                       err_beat,
  input  logic [AXI_ADD_W-1:0]                     gid_offset,
  input  logic [LDG_CMD_W-1:0]                     seq_ldg_cmd,
  input  logic                                     seq_ldg_vld,
  input  logic                                     seq_ldg_rdy,
  input  logic                                     ldg_seq_done,
  input  logic [AXI_ID_W-1:0]                      arid,
  input  logic [AXI_ADD_W-1:0]                     araddr,
  input  logic [7:0]                               arlen,
  input  logic [2:0]                               arsize,
  input  logic [1:0]                               arburst,
  input  logic                                     arvalid,
  input  logic                                     arready,
  input  logic                                     rready,
  input  logic [COEF_PER_BEAT-1:0]                 glwe_ram_wr_en,
  input  logic [COEF_PER_BEAT-1:0][GRAM_ADD_W-1:0] glwe_ram_wr_add,
  input  logic [COEF_PER_BEAT-1:0][COEF_W-1:0]     glwe_ram_wr_data,
  input  logic [LDG_ERR_W-1:0]                     error,
  output int                                       err_cnt,
  output int                                       chk_cnt
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int GRAM_DEPTH = SLOT_NB * BEAT_NB;

  // Model GRAM and per-command write tracking
  logic [COEF_W-1:0] gram    [GRAM_DEPTH][COEF_PER_BEAT];
  bit                written [GRAM_DEPTH][COEF_PER_BEAT];

  bit                busy      = 1'b0;
  bit                rst_q     = 1'b0;
  logic [GID_W-1:0]  cur_gid   = '0;
  logic [SLOT_W-1:0] cur_slot  = '0;
  int                cur_err   = -1;
  int                ar_cnt    = 0;
  int                err_seen  = 0;
  int                errs      = 0;
  int                checks    = 0;
  string             test_name = "reset";

  assign err_cnt = errs;
  assign chk_cnt = checks;

  function automatic logic [COEF_W-1:0] expected_coef(input logic [AXI_ADD_W-1:0] addr,
                                                      input int j);
    logic [AXI_ADD_W-1:0] idx;
    idx = (addr >> 3) * 4 + AXI_ADD_W'(j);
    return idx[COEF_W-1:0] ^ 16'h5A5A;
  endfunction

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errs++;
      $display("error %s %s: expected 0x%0h actual 0x%0h", test_name, what, exp, act);
    end
  endtask

  task automatic report(input string msg);
    errs++;
    $display("%s: %s", test_name, msg);
  endtask

  task automatic check_idle();
    if (!s_rst_n) begin
      compare("reset seq_ldg_rdy", 32'd0, 32'(seq_ldg_rdy));
    end
    compare("reset arvalid", 32'd0, 32'(arvalid));
    compare("reset rready", 32'd0, 32'(rready));
    compare("reset wr_en", 32'd0, 32'(glwe_ram_wr_en));
    compare("reset ldg_seq_done", 32'd0, 32'(ldg_seq_done));
    compare("reset error", 32'd0, 32'(error));
  endtask

  task automatic start_cmd();
    int a;
    int l;
    if (busy) begin
      report("a command was accepted before the previous one finished");
    end
    busy      = 1'b1;
    cur_gid   = seq_ldg_cmd[LDG_CMD_W-1 -: GID_W];
    cur_slot  = seq_ldg_cmd[SLOT_W-1:0];
    cur_err   = err_beat;
    test_name = $sformatf("line%0d", test_idx);
    ar_cnt    = 0;
    err_seen  = 0;
    for (a = 0; a < GRAM_DEPTH; a++) begin
      for (l = 0; l < COEF_PER_BEAT; l++) begin
        written[a][l] = 1'b0;
      end
    end
  endtask

  task automatic check_ar();
    ar_cnt++;
    if (!busy) begin
      report("AR handshake with no command running");
    end
    compare("araddr", gid_offset + AXI_ADD_W'(cur_gid) * AXI_ADD_W'(POLY_BYTES), araddr);
    compare("arlen", 32'(BEAT_NB - 1), 32'(arlen));
    compare("arsize", 32'd3, 32'(arsize));
    // INCR burst
    compare("arburst", 32'd1, 32'(arburst));
    compare("arid", 32'(LDG_AXI_ID), 32'(arid));
  endtask

  task automatic record_writes();
    int l;
    int a;
    for (l = 0; l < COEF_PER_BEAT; l++) begin
      if (glwe_ram_wr_en[l]) begin
        a = int'(glwe_ram_wr_add[l]);
        if (!busy) begin
          report($sformatf("lane %0d wrote with no command running", l));
        end else if (a / BEAT_NB != int'(cur_slot)) begin
          report($sformatf("lane %0d wrote address %0d outside slot %0d", l, a, cur_slot));
        end else if (written[a][l]) begin
          report($sformatf("lane %0d wrote address %0d twice", l, a));
        end else begin
          written[a][l] = 1'b1;
          gram[a][l]    = glwe_ram_wr_data[l];
        end
      end
    end
  endtask

  task automatic finish_cmd();
    int                   b;
    int                   l;
    int                   a;
    logic [AXI_ADD_W-1:0] base;
    if (!busy) begin
      report("ldg_seq_done pulsed with no command running");
    end else begin
      base = gid_offset + AXI_ADD_W'(cur_gid) * AXI_ADD_W'(POLY_BYTES);
      compare("AR handshakes", 32'd1, ar_cnt);
      compare("rresp error pulses", (cur_err >= 0) ? 32'd1 : 32'd0, err_seen);
      for (b = 0; b < BEAT_NB; b++) begin
        for (l = 0; l < COEF_PER_BEAT; l++) begin
          a = int'(cur_slot) * BEAT_NB + b;
          if (!written[a][l]) begin
            report($sformatf("beat %0d lane %0d was never written", b, l));
          end else begin
            compare($sformatf("coef beat %0d lane %0d", b, l),
                    32'(expected_coef(base + AXI_ADD_W'(b * 8), l)), 32'(gram[a][l]));
          end
        end
      end
      busy = 1'b0;
    end
  endtask

  // --------------------
  // Monitor
  // --------------------
  always @(negedge clk) begin
    if (!s_rst_n || !rst_q) begin
      check_idle();
    end
    rst_q = s_rst_n;
    if (s_rst_n) begin
      if (busy && !ldg_seq_done && seq_ldg_rdy) begin
        report("seq_ldg_rdy went high while a command was running");
      end
      if (arvalid && arready) begin
        check_ar();
      end
      record_writes();
      if (error[0]) begin
        err_seen++;
      end
      if (error[1]) begin
        report("error bit 1 set although every rid matched");
      end
      if (ldg_seq_done) begin
        finish_cmd();
      end
      if (seq_ldg_vld && seq_ldg_rdy) begin
        start_cmd();
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/ldg_patterns.txt ====
# columns: gid slot err_beat stall
# err_beat is the beat answered with SLVERR (-1 for none); stall 1 adds random AXI delays
0 0 -1 0
1 1 -1 0
255 3 -1 0
17 2 -1 1
42 0 3 0
42 1 -1 1
7 3 0 1
128 2 7 0
3 0 -1 1
99 1 -1 0
200 3 5 1
64 2 -1 1
5 0 -1 0
5 0 -1 1
31 1 1 0
250 2 -1 1
11 3 -1 0
77 0 6 1
160 1 -1 1
2 2 -1 0

// ==== verification/tb_ldg.sv ====
// Run from the project root so the pattern file resolves; commands are issued one at a time
`default_nettype none

module tb_ldg
  import ldg_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int                   RST_CYCLES = 16;
  localparam logic [AXI_ADD_W-1:0] GID_BASE   = 32'h0004_0000;

  logic                                     clk          = 1'b0;
  logic                                     s_rst_n      = 1'b0;
  logic [AXI_ADD_W-1:0]                     gid_offset   = GID_BASE;
  logic [LDG_CMD_W-1:0]                     seq_ldg_cmd  = '0;
  logic                                     seq_ldg_vld  = 1'b0;
  logic                                     seq_ldg_rdy;
  logic                                     ldg_seq_done;
  logic [AXI_ID_W-1:0]                      arid;
  logic [AXI_ADD_W-1:0]                     araddr;
  logic [7:0]                               arlen;
  logic [2:0]                               arsize;
  logic [1:0]                               arburst;
  logic                                     arvalid;
  logic                                     arready      = 1'b0;
  logic [AXI_ID_W-1:0]                      rid          = LDG_AXI_ID;
  logic [AXI_DATA_W-1:0]                    rdata        = '0;
  logic [1:0]                               rresp        = 2'b00;
  logic                                     rlast        = 1'b0;
  logic                                     rvalid       = 1'b0;
  logic                                     rready;
  logic [COEF_PER_BEAT-1:0]                 glwe_ram_wr_en;
  logic [COEF_PER_BEAT-1:0][GRAM_ADD_W-1:0] glwe_ram_wr_add;
  logic [COEF_PER_BEAT-1:0][COEF_W-1:0]     glwe_ram_wr_data;
  logic [LDG_ERR_W-1:0]                     error;

  // Pattern table, one entry per command
  logic [GID_W-1:0]  gid_tab[$];
  logic [SLOT_W-1:0] slot_tab[$];
  int                err_tab[$];
  bit                stall_tab[$];

  int test_idx     = 0;
  int err_beat     = -1;
  bit stall        = 1'b0;
  int limit_cycles = 0;
  int tb_errs      = 0;
  int err_cnt;
  int chk_cnt;

  // AXI slave state
  logic [AXI_ADD_W-1:0] rd_addr  = '0;
  bit                   burst_on = 1'b0;
  int                   beat     = 0;
  int                   nb       = 0;
  int                   ar_gap   = 0;
  int                   r_gap    = 0;

  always #20 clk = ~clk;

  ldg_assembly #(
    .SLR_LATENCY (6)
  ) DUT (
    .clk (clk), .s_rst_n (s_rst_n), .gid_offset (gid_offset),
    .seq_ldg_cmd (seq_ldg_cmd), .seq_ldg_vld (seq_ldg_vld),
    .seq_ldg_rdy (seq_ldg_rdy), .ldg_seq_done (ldg_seq_done),
    .arid (arid), .araddr (araddr), .arlen (arlen), .arsize (arsize),
    .arburst (arburst), .arvalid (arvalid), .arready (arready),
    .rid (rid), .rdata (rdata), .rresp (rresp), .rlast (rlast),
    .rvalid (rvalid), .rready (rready),
    .glwe_ram_wr_en (glwe_ram_wr_en), .glwe_ram_wr_add (glwe_ram_wr_add),
    .glwe_ram_wr_data (glwe_ram_wr_data), .error (error)
  );

  ldg_checker u_checker (
    .clk (clk), .s_rst_n (s_rst_n), .test_idx (test_idx), .err_beat (err_beat),
    .gid_offset (gid_offset), .seq_ldg_cmd (seq_ldg_cmd),
    .seq_ldg_vld (seq_ldg_vld), .seq_ldg_rdy (seq_ldg_rdy),
    .ldg_seq_done (ldg_seq_done), .arid (arid), .araddr (araddr),
    .arlen (arlen), .arsize (arsize), .arburst (arburst),
    .arvalid (arvalid), .arready (arready), .rready (rready),
    .glwe_ram_wr_en (glwe_ram_wr_en), .glwe_ram_wr_add (glwe_ram_wr_add),
    .glwe_ram_wr_data (glwe_ram_wr_data), .error (error),
    .err_cnt (err_cnt), .chk_cnt (chk_cnt)
  );

  // Memory contents: coefficient j of the word at byte address A
  function automatic logic [AXI_DATA_W-1:0] mem_word(input logic [AXI_ADD_W-1:0] addr);
    logic [AXI_DATA_W-1:0] w;
    logic [AXI_ADD_W-1:0]  idx;
    int                    j;
    for (j = 0; j < COEF_PER_BEAT; j++) begin
      idx = (addr >> 3) * 4 + AXI_ADD_W'(j);
      w[j*COEF_W +: COEF_W] = idx[COEF_W-1:0] ^ 16'h5A5A;
    end
    return w;
  endfunction

  function automatic int stall_gap();
    if (stall) begin
      return int'($urandom_range(3, 0));
    end
    return 0;
  endfunction

  // --------------------
  // AXI read slave
  // --------------------
  always @(posedge clk) begin
    if (!s_rst_n) begin
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      rlast    <= 1'b0;
      burst_on <= 1'b0;
      ar_gap   <= 0;
    end else begin
      if (arvalid && arready) begin
        arready  <= 1'b0;
        rd_addr  <= araddr;
        burst_on <= 1'b1;
        beat     <= 0;
        r_gap    <= stall_gap();
      end else if (arvalid) begin
        if (ar_gap == 0) begin
          arready <= 1'b1;
          ar_gap  <= stall_gap();
        end else begin
          ar_gap <= ar_gap - 1;
        end
      end
      // A beat on offer holds until taken
      if (burst_on && !(rvalid && !rready)) begin
        nb = rvalid ? beat + 1 : beat;
        beat <= nb;
        if (nb == BEAT_NB) begin
          rvalid   <= 1'b0;
          burst_on <= 1'b0;
        end else if (r_gap == 0) begin
          rvalid <= 1'b1;
          rdata  <= mem_word(rd_addr + AXI_ADD_W'(nb * 8));
          rresp  <= (nb == err_beat) ? 2'b10 : 2'b00;
          rlast  <= (nb == BEAT_NB - 1);
          r_gap  <= stall_gap();
        end else begin
          rvalid <= 1'b0;
          r_gap  <= r_gap - 1;
        end
      end
    end
  end

  // --------------------
  // Commands
  // --------------------
  initial begin : stimulus
    int    fd;
    int    got;
    int    g;
    int    s;
    int    e;
    int    st;
    int    i;
    string line;
    got = $urandom(33666);
    fd = $fopen("verification/ldg_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file verification/ldg_patterns.txt");
      tb_errs++;
    end else begin
      while (!$feof(fd)) begin
        got = $fgets(line, fd);
        if (got > 0 && $sscanf(line, "%d %d %d %d", g, s, e, st) == 4) begin
          gid_tab.push_back(GID_W'(g));
          slot_tab.push_back(SLOT_W'(s));
          err_tab.push_back(e);
          stall_tab.push_back(st != 0);
        end
      end
      $fclose(fd);
    end
    if (gid_tab.size() == 0) begin
      $display("the pattern file held no commands");
      tb_errs++;
    end
    limit_cycles = gid_tab.size() * 200 + RST_CYCLES + 20;

    repeat (RST_CYCLES) @(posedge clk);
    s_rst_n <= 1'b1;
    for (i = 0; i < gid_tab.size(); i++) begin
      @(posedge clk);
      seq_ldg_cmd <= {gid_tab[i], slot_tab[i]};
      seq_ldg_vld <= 1'b1;
      stall       <= stall_tab[i];
      err_beat    <= err_tab[i];
      test_idx    <= i;
      @(posedge clk);
      while (!seq_ldg_rdy) @(posedge clk);
      seq_ldg_vld <= 1'b0;
      @(posedge clk);
      while (!ldg_seq_done) @(posedge clk);
    end

    // Room for stray pulses to show up
    repeat (10) @(posedge clk);
    $display("closing: %0d checks, %0d errors", chk_cnt, err_cnt + tb_errs);
    if (err_cnt + tb_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: the commands did not finish within %0d cycles", limit_cycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/ldg_assembly.sv ====
// SLR_LATENCY is 0 for direct wires or at least 2; it is split into outward and return halves
`default_nettype none

module ldg_assembly
  import ldg_pkg::*;
#(
  parameter int SLR_LATENCY = 6
) (
  input  logic                                     clk,
  input  logic                                     s_rst_n,
  input  logic [AXI_ADD_W-1:0]                     gid_offset,

  input  logic [LDG_CMD_W-1:0]                     seq_ldg_cmd,
  input  logic                                     seq_ldg_vld,
  output logic                                     seq_ldg_rdy,
  output logic                                     ldg_seq_done,

  output logic [AXI_ID_W-1:0]                      arid,
  output logic [AXI_ADD_W-1:0]                     araddr,
  output logic [7:0]                               arlen,
  output logic [2:0]                               arsize,
  output logic [1:0]                               arburst,
  output logic                                     arvalid,
  input  logic                                     arready,
  input  logic [AXI_ID_W-1:0]                      rid,
  input  logic [AXI_DATA_W-1:0]                    rdata,
  input  logic [1:0]                               rresp,
  input  logic                                     rlast,
  input  logic                                     rvalid,
  output logic                                     rready,

  // Lanes 3 and 2 from main, 1 and 0 from subs
  output logic [COEF_PER_BEAT-1:0]                 glwe_ram_wr_en,
  output logic [COEF_PER_BEAT-1:0][GRAM_ADD_W-1:0] glwe_ram_wr_add,
  output logic [COEF_PER_BEAT-1:0][COEF_W-1:0]     glwe_ram_wr_data,
  output logic [LDG_ERR_W-1:0]                     error
);

  localparam int OUTWARD_SLR_LATENCY = SLR_LATENCY / 2;
  localparam int RETURN_SLR_LATENCY  = SLR_LATENCY - OUTWARD_SLR_LATENCY;

  if (SLR_LATENCY == 1) begin : gen_bad_latency
    $fatal(1, "SLR_LATENCY of 1 is not supported, use 0 or at least 2");
  end

  // Main side of the crossing
  logic [LDG_CMD_W-1:0]                 main_cmd;
  logic                                 main_cmd_vld;
  logic                                 main_cmd_rdy;
  logic                                 main_done;
  logic [HALF_COEF-1:0][COEF_W-1:0]     main_data;
  logic                                 main_data_vld;
  logic                                 main_data_rdy;

  // Subs side of the crossing
  logic [LDG_CMD_W-1:0]                 subs_cmd;
  logic                                 subs_cmd_vld;
  logic                                 subs_cmd_rdy;
  logic                                 subs_done;
  logic [HALF_COEF-1:0][COEF_W-1:0]     subs_data;
  logic                                 subs_data_vld;
  logic                                 subs_data_rdy;

  logic [HALF_COEF-1:0]                 main_wr_en;
  logic [HALF_COEF-1:0][GRAM_ADD_W-1:0] main_wr_add;
  logic [HALF_COEF-1:0][COEF_W-1:0]     main_wr_data;
  logic [HALF_COEF-1:0]                 subs_wr_en;
  logic [HALF_COEF-1:0][GRAM_ADD_W-1:0] subs_wr_add;
  logic [HALF_COEF-1:0][COEF_W-1:0]     subs_wr_data;
  logic [LDG_ERR_W-1:0]                 main_error;
  logic [LDG_ERR_W-1:0]                 subs_error;

  assign glwe_ram_wr_en   = {main_wr_en, subs_wr_en};
  assign glwe_ram_wr_add  = {main_wr_add, subs_wr_add};
  assign glwe_ram_wr_data = {main_wr_data, subs_wr_data};

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      error <= '0;
    end else begin
      error <= main_error | subs_error;
    end
  end

  // --------------------
  // Crossing
  // --------------------
  if (SLR_LATENCY == 0) begin : gen_direct
    assign subs_cmd      = main_cmd;
    assign subs_cmd_vld  = main_cmd_vld;
    assign main_cmd_rdy  = subs_cmd_rdy;
    assign subs_data     = main_data;
    assign subs_data_vld = main_data_vld;
    assign main_data_rdy = subs_data_rdy;
    assign main_done     = subs_done;
  end else begin : gen_pipe
    logic [RETURN_SLR_LATENCY-1:0] done_sr;

    ldg_slr_fifo #(
      .WIDTH (LDG_CMD_W),
      .DEPTH (OUTWARD_SLR_LATENCY)
    ) u_cmd_fifo (
      .clk      (clk),
      .s_rst_n  (s_rst_n),
      .in_data  (main_cmd),
      .in_vld   (main_cmd_vld),
      .in_rdy   (main_cmd_rdy),
      .out_data (subs_cmd),
      .out_vld  (subs_cmd_vld),
      .out_rdy  (subs_cmd_rdy)
    );

    ldg_slr_fifo #(
      .WIDTH (HALF_COEF * COEF_W),
      .DEPTH (OUTWARD_SLR_LATENCY)
    ) u_data_fifo (
      .clk      (clk),
      .s_rst_n  (s_rst_n),
      .in_data  (main_data),
      .in_vld   (main_data_vld),
      .in_rdy   (main_data_rdy),
      .out_data (subs_data),
      .out_vld  (subs_data_vld),
      .out_rdy  (subs_data_rdy)
    );

    // Done travels back as a plain pulse
    always_ff @(posedge clk) begin
      if (!s_rst_n) begin
        done_sr <= '0;
      end else begin
        done_sr[0] <= subs_done;
        for (int i = 1; i < RETURN_SLR_LATENCY; i++) begin
          done_sr[i] <= done_sr[i-1];
        end
      end
    end

    assign main_done = done_sr[RETURN_SLR_LATENCY-1];
  end

  // --------------------
  // Halves
  // --------------------
  ldg_main u_main (
    .clk           (clk),
    .s_rst_n       (s_rst_n),
    .gid_offset    (gid_offset),
    .seq_ldg_cmd   (seq_ldg_cmd),
    .seq_ldg_vld   (seq_ldg_vld),
    .seq_ldg_rdy   (seq_ldg_rdy),
    .ldg_seq_done  (ldg_seq_done),
    .arid          (arid),
    .araddr        (araddr),
    .arlen         (arlen),
    .arsize        (arsize),
    .arburst       (arburst),
    .arvalid       (arvalid),
    .arready       (arready),
    .rid           (rid),
    .rdata         (rdata),
    .rresp         (rresp),
    .rlast         (rlast),
    .rvalid        (rvalid),
    .rready        (rready),
    .subs_cmd      (main_cmd),
    .subs_cmd_vld  (main_cmd_vld),
    .subs_cmd_rdy  (main_cmd_rdy),
    .subs_cmd_done (main_done),
    .subs_data     (main_data),
    .subs_data_vld (main_data_vld),
    .subs_data_rdy (main_data_rdy),
    .main_wr_en    (main_wr_en),
    .main_wr_add   (main_wr_add),
    .main_wr_data  (main_wr_data),
    .main_error    (main_error)
  );

  ldg_subs u_subs (
    .clk           (clk),
    .s_rst_n       (s_rst_n),
    .subs_cmd      (subs_cmd),
    .subs_cmd_vld  (subs_cmd_vld),
    .subs_cmd_rdy  (subs_cmd_rdy),
    .subs_cmd_done (subs_done),
    .subs_data     (subs_data),
    .subs_data_vld (subs_data_vld),
    .subs_data_rdy (subs_data_rdy),
    .subs_wr_en    (subs_wr_en),
    .subs_wr_add   (subs_wr_add),
    .subs_wr_data  (subs_wr_data),
    .subs_error    (subs_error)
  );

endmodule

`default_nettype wire

// ==== verilog/ldg_main.sv ====
// One command at a time; the next is taken only after subs reports done for the current one
`default_nettype none

module ldg_main
  import ldg_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 s_rst_n,
  input  logic [AXI_ADD_W-1:0]                 gid_offset,

  input  logic [LDG_CMD_W-1:0]                 seq_ldg_cmd,
  input  logic                                 seq_ldg_vld,
  output logic                                 seq_ldg_rdy,
  output logic                                 ldg_seq_done,

  output logic [AXI_ID_W-1:0]                  arid,
  output logic [AXI_ADD_W-1:0]                 araddr,
  output logic [7:0]                           arlen,
  output logic [2:0]                           arsize,
  output logic [1:0]                           arburst,
  output logic                                 arvalid,
  input  logic                                 arready,
  input  logic [AXI_ID_W-1:0]                  rid,
  input  logic [AXI_DATA_W-1:0]                rdata,
  input  logic [1:0]                           rresp,
  input  logic                                 rlast,
  input  logic                                 rvalid,
  output logic                                 rready,

  output logic [LDG_CMD_W-1:0]                 subs_cmd,
  output logic                                 subs_cmd_vld,
  input  logic                                 subs_cmd_rdy,
  input  logic                                 subs_cmd_done,

  output logic [HALF_COEF-1:0][COEF_W-1:0]     subs_data,
  output logic                                 subs_data_vld,
  input  logic                                 subs_data_rdy,

  output logic [HALF_COEF-1:0]                 main_wr_en,
  output logic [HALF_COEF-1:0][GRAM_ADD_W-1:0] main_wr_add,
  output logic [HALF_COEF-1:0][COEF_W-1:0]     main_wr_data,
  output logic [LDG_ERR_W-1:0]                 main_error
);

  localparam int         BEAT_W    = $clog2(BEAT_NB);
  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_ADDR   = 2'd1;
  localparam logic [1:0] ST_BURST  = 2'd2;
  localparam logic [1:0] ST_WAIT   = 2'd3;
  localparam logic [1:0] RESP_OKAY = 2'b00;

  logic [1:0]            state;
  logic [1:0]            state_next;
  logic [SLOT_W-1:0]     slot;
  logic [BEAT_W-1:0]     beat_cnt;
  logic [GRAM_ADD_W-1:0] beat_add;
  logic                  cmd_acc;
  logic                  beat_ok;
  logic                  last_beat;
  ldg_data_u             rd_word;

  assign cmd_acc   = seq_ldg_vld & seq_ldg_rdy;
  assign beat_ok   = rvalid & rready;
  assign last_beat = beat_ok & (beat_cnt == BEAT_W'(BEAT_NB - 1));
  assign rd_word   = rdata;
  assign beat_add  = GRAM_ADD_W'(slot * BEAT_NB) + GRAM_ADD_W'(beat_cnt);

  // --------------------
  // FSM
  // --------------------
  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE:  if (cmd_acc) state_next = ST_ADDR;
      ST_ADDR:  if (arready) state_next = ST_BURST;
      ST_BURST: if (last_beat) state_next = ST_WAIT;
      default:  if (subs_cmd_done) state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      state        <= ST_IDLE;
      seq_ldg_rdy  <= 1'b0;
      ldg_seq_done <= 1'b0;
      subs_cmd_vld <= 1'b0;
      beat_cnt     <= '0;
      main_wr_en   <= '0;
    end else begin
      state        <= state_next;
      seq_ldg_rdy  <= (state_next == ST_IDLE);
      ldg_seq_done <= (state == ST_WAIT) & subs_cmd_done;
      // Command goes to subs right at acceptance
      if (cmd_acc) begin
        subs_cmd_vld <= 1'b1;
      end else if (subs_cmd_rdy) begin
        subs_cmd_vld <= 1'b0;
      end
      if (last_beat) begin
        beat_cnt <= '0;
      end else if (beat_ok) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
      main_wr_en <= {HALF_COEF{beat_ok}};
    end
  end

  // --------------------
  // AXI read
  // --------------------
  assign arid    = LDG_AXI_ID;
  assign arlen   = 8'(BEAT_NB - 1);
  // 8 bytes per beat, incrementing
  assign arsize  = 3'd3;
  assign arburst = 2'b01;
  assign arvalid = (state == ST_ADDR);
  assign rready  = (state == ST_BURST) & subs_data_rdy;

  always_ff @(posedge clk) begin
    if (cmd_acc) begin
      subs_cmd <= seq_ldg_cmd;
      slot     <= seq_ldg_cmd[SLOT_W-1:0];
      araddr   <= gid_offset
                + AXI_ADD_W'(POLY_BYTES) * AXI_ADD_W'(seq_ldg_cmd[LDG_CMD_W-1 -: GID_W]);
    end
  end

  // --------------------
  // Beat split
  // --------------------
  // Lower half crosses to subs in the beat cycle
  assign subs_data     = rd_word.half.subs_half;
  assign subs_data_vld = (state == ST_BURST) & rvalid;

  always_ff @(posedge clk) begin
    main_wr_add  <= {HALF_COEF{beat_add}};
    main_wr_data <= rd_word.half.main_half;
  end

  assign main_error[0] = beat_ok & (rresp != RESP_OKAY);
  assign main_error[1] = beat_ok & (rid != LDG_AXI_ID);

  a_rlast_on_last_beat: assert property (@(posedge clk) disable iff (!s_rst_n)
    beat_ok |-> (rlast == (beat_cnt == BEAT_W'(BEAT_NB - 1))))
    else $error("rlast seen out of place at beat %0d", beat_cnt);

endmodule

`default_nettype wire

// ==== verilog/ldg_pkg.sv ====
// Sizes are tied together: changing POLY_N, COEF_W or AXI_DATA_W reshapes the beat and GRAM maps
`default_nettype none

package ldg_pkg;

  // --------------------
  // Polynomial and bus sizes
  // --------------------
  localparam int COEF_W        = 16;
  localparam int AXI_DATA_W    = 64;
  localparam int AXI_ADD_W     = 32;
  localparam int AXI_ID_W      = 4;
  localparam int COEF_PER_BEAT = AXI_DATA_W / COEF_W;
  localparam int HALF_COEF     = COEF_PER_BEAT / 2;
  localparam int POLY_N        = 32;
  localparam int BEAT_NB       = POLY_N / COEF_PER_BEAT;
  localparam int POLY_BYTES    = POLY_N * COEF_W / 8;

  // --------------------
  // Command and GRAM
  // --------------------
  localparam int GID_W      = 8;
  localparam int SLOT_NB    = 4;
  localparam int SLOT_W     = $clog2(SLOT_NB);
  // GLWE id sits above the slot
  localparam int LDG_CMD_W  = GID_W + SLOT_W;
  localparam int GRAM_ADD_W = $clog2(SLOT_NB * BEAT_NB);

  localparam logic [AXI_ID_W-1:0] LDG_AXI_ID = 4'h3;

  // Bit 0 bad rresp, bit 1 unexpected rid
  localparam int LDG_ERR_W = 2;

  // One read beat, seen as four coefficients or as the two split halves
  typedef union packed {
    logic [COEF_PER_BEAT-1:0][COEF_W-1:0] coef;
    struct packed {
      logic [HALF_COEF-1:0][COEF_W-1:0] main_half;
      logic [HALF_COEF-1:0][COEF_W-1:0] subs_half;
    } half;
  } ldg_data_u;

endpackage

`default_nettype wire

// ==== verilog/ldg_slr_fifo.sv ====
// DEPTH must be at least 1; the ready path is combinational through every stage of the chain
`default_nettype none

module ldg_slr_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2
) (
  input  logic             clk,
  input  logic             s_rst_n,

  input  logic [WIDTH-1:0] in_data,
  input  logic             in_vld,
  output logic             in_rdy,

  output logic [WIDTH-1:0] out_data,
  output logic             out_vld,
  input  logic             out_rdy
);

  logic [WIDTH-1:0] stage_data [DEPTH];
  logic             stage_vld  [DEPTH];
  // Stage can take a new item this cycle
  logic             stage_rdy  [DEPTH];

  for (genvar i = 0; i < DEPTH; i++) begin : gen_stage
    logic [WIDTH-1:0] prev_data;
    logic             prev_vld;
    logic             next_rdy;

    if (i == 0) begin : gen_first
      assign prev_data = in_data;
      assign prev_vld  = in_vld;
    end else begin : gen_inner
      assign prev_data = stage_data[i-1];
      assign prev_vld  = stage_vld[i-1];
    end

    if (i == DEPTH - 1) begin : gen_last
      assign next_rdy = out_rdy;
    end else begin : gen_chain
      assign next_rdy = stage_rdy[i+1];
    end

    // Empty, or the current item moves on this cycle
    assign stage_rdy[i] = ~stage_vld[i] | next_rdy;

    always_ff @(posedge clk) begin
      if (!s_rst_n) begin
        stage_vld[i] <= 1'b0;
      end else if (stage_rdy[i]) begin
        stage_vld[i] <= prev_vld;
      end
    end

    always_ff @(posedge clk) begin
      if (stage_rdy[i] && prev_vld) begin
        stage_data[i] <= prev_data;
      end
    end
  end

  assign in_rdy   = stage_rdy[0];
  assign out_data = stage_data[DEPTH-1];
  assign out_vld  = stage_vld[DEPTH-1];

  // Output item held until taken
  a_out_stable: assert property (@(posedge clk) disable iff (!s_rst_n)
    (out_vld && !out_rdy) |=> (out_vld && $stable(out_data)))
    else $error("crossing FIFO output changed while stalled");

endmodule

`default_nettype wire

// ==== verilog/ldg_subs.sv ====
// Only the slot field of the command is used here; the GLWE id is consumed by main
`default_nettype none

module ldg_subs
  import ldg_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 s_rst_n,

  input  logic [LDG_CMD_W-1:0]                 subs_cmd,
  input  logic                                 subs_cmd_vld,
  output logic                                 subs_cmd_rdy,
  output logic                                 subs_cmd_done,

  input  logic [HALF_COEF-1:0][COEF_W-1:0]     subs_data,
  input  logic                                 subs_data_vld,
  output logic                                 subs_data_rdy,

  output logic [HALF_COEF-1:0]                 subs_wr_en,
  output logic [HALF_COEF-1:0][GRAM_ADD_W-1:0] subs_wr_add,
  output logic [HALF_COEF-1:0][COEF_W-1:0]     subs_wr_data,
  output logic [LDG_ERR_W-1:0]                 subs_error
);

  localparam int BEAT_W = $clog2(BEAT_NB);

  logic                  cmd_held;
  logic [SLOT_W-1:0]     slot;
  logic [BEAT_W-1:0]     beat_cnt;
  logic [GRAM_ADD_W-1:0] beat_add;
  logic                  data_ok;
  logic                  last_wr;

  assign subs_cmd_rdy  = ~cmd_held;
  assign subs_data_rdy = cmd_held;
  assign data_ok       = subs_data_vld & cmd_held;
  assign beat_add      = GRAM_ADD_W'(slot * BEAT_NB) + GRAM_ADD_W'(beat_cnt);
  // Nothing checked on this side yet
  assign subs_error    = '0;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      cmd_held      <= 1'b0;
      beat_cnt      <= '0;
      last_wr       <= 1'b0;
      subs_cmd_done <= 1'b0;
      subs_wr_en    <= '0;
    end else begin
      // Command released together with the done pulse
      if (subs_cmd_vld && !cmd_held) begin
        cmd_held <= 1'b1;
      end else if (last_wr) begin
        cmd_held <= 1'b0;
      end
      if (data_ok) begin
        beat_cnt <= (beat_cnt == BEAT_W'(BEAT_NB - 1)) ? '0 : beat_cnt + 1'b1;
      end
      last_wr       <= data_ok & (beat_cnt == BEAT_W'(BEAT_NB - 1));
      subs_cmd_done <= last_wr;
      subs_wr_en    <= {HALF_COEF{data_ok}};
    end
  end

  always_ff @(posedge clk) begin
    if (subs_cmd_vld && !cmd_held) begin
      slot <= subs_cmd[SLOT_W-1:0];
    end
    subs_wr_add  <= {HALF_COEF{beat_add}};
    subs_wr_data <= subs_data;
  end

  // Main sends the command ahead of the first beat
  a_data_after_cmd: assert property (@(posedge clk) disable iff (!s_rst_n)
    subs_data_vld |-> cmd_held)
    else $error("subs data arrived with no command held");

endmodule

`default_nettype wire
